/* Bender.yml */
package:
  name: retire_core

sources:
  - files:
      - design/retire_pkg.sv
      - design/hilo_unit.sv
      - design/writeback_select.sv
      - design/gpr_file.sv
      - design/retire_core.sv
  - target: test
    files:
      - verification/retire_checker.sv
      - verification/tb_retire.sv

/* design/gpr_file.sv */
`timescale 1ns/1ns
`default_nettype none

module gpr_file (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              i_old_we,
    input  logic                              i_new_we,
    input  logic [retire_pkg::REG_ADDR_W-1:0] i_old_wa,
    input  logic [retire_pkg::REG_ADDR_W-1:0] i_new_wa,
    input  logic [retire_pkg::WORD_W-1:0]     i_old_wd,
    input  logic [retire_pkg::WORD_W-1:0]     i_new_wd,
    input  logic [retire_pkg::REG_ADDR_W-1:0] i_ra_a,
    input  logic [retire_pkg::REG_ADDR_W-1:0] i_ra_b,
    output logic [retire_pkg::WORD_W-1:0]     o_rd_a,
    output logic [retire_pkg::WORD_W-1:0]     o_rd_b
);

    // register 0 has no storage
    logic [retire_pkg::WORD_W-1:0] regs [1:retire_pkg::NUM_REGS-1];

    logic [retire_pkg::WORD_W-1:0] stored_a;
    logic [retire_pkg::WORD_W-1:0] stored_b;

    // newer write first, then older, then the array
    function automatic logic [retire_pkg::WORD_W-1:0] read_port(
        input logic [retire_pkg::REG_ADDR_W-1:0] ra,
        input logic [retire_pkg::WORD_W-1:0]     stored,
        input logic                              old_we,
        input logic [retire_pkg::REG_ADDR_W-1:0] old_wa,
        input logic [retire_pkg::WORD_W-1:0]     old_wd,
        input logic                              new_we,
        input logic [retire_pkg::REG_ADDR_W-1:0] new_wa,
        input logic [retire_pkg::WORD_W-1:0]     new_wd
    );
        if (ra == '0) begin
            return '0;
        end else if (new_we && new_wa == ra) begin
            return new_wd;
        end else if (old_we && old_wa == ra) begin
            return old_wd;
        end
        return stored;
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < retire_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (i_old_we && i_old_wa != '0) begin
                regs[i_old_wa] <= i_old_wd;
            end
            // the later assignment wins on a shared destination
            if (i_new_we && i_new_wa != '0) begin
                regs[i_new_wa] <= i_new_wd;
            end
        end
    end

    always_comb begin
        stored_a = (i_ra_a == '0) ? '0 : regs[i_ra_a];
        stored_b = (i_ra_b == '0) ? '0 : regs[i_ra_b];
        o_rd_a = read_port(i_ra_a, stored_a, i_old_we, i_old_wa, i_old_wd,
                           i_new_we, i_new_wa, i_new_wd);
        o_rd_b = read_port(i_ra_b, stored_b, i_old_we, i_old_wa, i_old_wd,
                           i_new_we, i_new_wa, i_new_wd);
    end

endmodule

`default_nettype wire

/* design/hilo_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module hilo_unit (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              i_old_valid,
    input  logic                              i_new_valid,
    input  retire_pkg::retire_op_t            i_old_op,
    input  retire_pkg::retire_op_t            i_new_op,
    input  logic [retire_pkg::WORD_W-1:0]     i_old_value,
    input  logic [retire_pkg::WORD_W-1:0]     i_new_value,
    input  logic [retire_pkg::DWORD_W-1:0]    i_old_product,
    input  logic [retire_pkg::DWORD_W-1:0]    i_new_product,
    output logic [retire_pkg::WORD_W-1:0]     o_hi,
    output logic [retire_pkg::WORD_W-1:0]     o_lo,
    output logic [retire_pkg::WORD_W-1:0]     o_mid_hi,
    output logic [retire_pkg::WORD_W-1:0]     o_mid_lo
);

    // one slot's effect on the {hi, lo} pair
    function automatic logic [retire_pkg::DWORD_W-1:0] apply_slot(
        input logic                           valid,
        input retire_pkg::retire_op_t         op,
        input logic [retire_pkg::WORD_W-1:0]  value,
        input logic [retire_pkg::DWORD_W-1:0] product,
        input logic [retire_pkg::DWORD_W-1:0] pair
    );
        logic [retire_pkg::DWORD_W-1:0] res;
        res = pair;
        if (valid) begin
            case (op)
                retire_pkg::OP_MTHI: begin
                    res[retire_pkg::DWORD_W-1:retire_pkg::WORD_W] = value;
                end
                retire_pkg::OP_MTLO: begin
                    res[retire_pkg::WORD_W-1:0] = value;
                end
                retire_pkg::OP_MULT: begin
                    res = product;
                end
                // wraps modulo 2^64
                retire_pkg::OP_MADD: begin
                    res = pair + product;
                end
                retire_pkg::OP_MSUB: begin
                    res = pair - product;
                end
                default: begin
                    res = pair;
                end
            endcase
        end
        return res;
    endfunction

    logic [retire_pkg::WORD_W-1:0]  hi_q;
    logic [retire_pkg::WORD_W-1:0]  lo_q;
    logic [retire_pkg::DWORD_W-1:0] mid_pair;
    logic [retire_pkg::DWORD_W-1:0] next_pair;

    // older slot works on the stored pair, newer slot chains on its result
    always_comb begin
        mid_pair = apply_slot(i_old_valid, i_old_op, i_old_value, i_old_product,
                              {hi_q, lo_q});
        next_pair = apply_slot(i_new_valid, i_new_op, i_new_value, i_new_product,
                               mid_pair);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi_q <= '0;
            lo_q <= '0;
        end else begin
            hi_q <= next_pair[retire_pkg::DWORD_W-1:retire_pkg::WORD_W];
            lo_q <= next_pair[retire_pkg::WORD_W-1:0];
        end
    end

    assign o_hi = hi_q;
    assign o_lo = lo_q;

    // what the newer slot sees
    assign o_mid_hi = mid_pair[retire_pkg::DWORD_W-1:retire_pkg::WORD_W];
    assign o_mid_lo = mid_pair[retire_pkg::WORD_W-1:0];

endmodule

`default_nettype wire

/* design/retire_core.sv */
`timescale 1ns/1ns
`default_nettype none

module retire_core (
    input  logic                              clk,
    input  logic                              reset,
    // older slot
    input  logic                              i_old_valid,
    input  retire_pkg::retire_op_t            i_old_op,
    input  logic [retire_pkg::REG_ADDR_W-1:0] i_old_rdst,
    input  logic [retire_pkg::WORD_W-1:0]     i_old_value,
    input  logic [retire_pkg::DWORD_W-1:0]    i_old_product,
    // newer slot
    input  logic                              i_new_valid,
    input  retire_pkg::retire_op_t            i_new_op,
    input  logic [retire_pkg::REG_ADDR_W-1:0] i_new_rdst,
    input  logic [retire_pkg::WORD_W-1:0]     i_new_value,
    input  logic [retire_pkg::DWORD_W-1:0]    i_new_product,
    // read ports
    input  logic [retire_pkg::REG_ADDR_W-1:0] i_ra_a,
    input  logic [retire_pkg::REG_ADDR_W-1:0] i_ra_b,
    output logic [retire_pkg::WORD_W-1:0]     o_rd_a,
    output logic [retire_pkg::WORD_W-1:0]     o_rd_b,
    output logic [retire_pkg::WORD_W-1:0]     o_hi,
    output logic [retire_pkg::WORD_W-1:0]     o_lo
);

    logic [retire_pkg::WORD_W-1:0]     mid_hi;
    logic [retire_pkg::WORD_W-1:0]     mid_lo;
    logic                              old_we;
    logic                              new_we;
    logic [retire_pkg::REG_ADDR_W-1:0] old_wa;
    logic [retire_pkg::REG_ADDR_W-1:0] new_wa;
    logic [retire_pkg::WORD_W-1:0]     old_wd;
    logic [retire_pkg::WORD_W-1:0]     new_wd;

    hilo_unit i_hilo_unit (
        .clk           (clk),
        .reset         (reset),
        .i_old_valid   (i_old_valid),
        .i_new_valid   (i_new_valid),
        .i_old_op      (i_old_op),
        .i_new_op      (i_new_op),
        .i_old_value   (i_old_value),
        .i_new_value   (i_new_value),
        .i_old_product (i_old_product),
        .i_new_product (i_new_product),
        .o_hi          (o_hi),
        .o_lo          (o_lo),
        .o_mid_hi      (mid_hi),
        .o_mid_lo      (mid_lo)
    );

    writeback_select i_writeback_select (
        .i_old_valid (i_old_valid),
        .i_new_valid (i_new_valid),
        .i_old_op    (i_old_op),
        .i_new_op    (i_new_op),
        .i_old_rdst  (i_old_rdst),
        .i_new_rdst  (i_new_rdst),
        .i_old_value (i_old_value),
        .i_new_value (i_new_value),
        .i_hi        (o_hi),
        .i_lo        (o_lo),
        .i_mid_hi    (mid_hi),
        .i_mid_lo    (mid_lo),
        .o_old_we    (old_we),
        .o_new_we    (new_we),
        .o_old_wa    (old_wa),
        .o_new_wa    (new_wa),
        .o_old_wd    (old_wd),
        .o_new_wd    (new_wd)
    );

    gpr_file i_gpr_file (
        .clk      (clk),
        .reset    (reset),
        .i_old_we (old_we),
        .i_new_we (new_we),
        .i_old_wa (old_wa),
        .i_new_wa (new_wa),
        .i_old_wd (old_wd),
        .i_new_wd (new_wd),
        .i_ra_a   (i_ra_a),
        .i_ra_b   (i_ra_b),
        .o_rd_a   (o_rd_a),
        .o_rd_b   (o_rd_b)
    );

endmodule

`default_nettype wire

/* design/retire_pkg.sv */
`default_nettype none

package retire_pkg;

    // word sizes
    localparam int WORD_W = 32;
    localparam int DWORD_W = 64;

    // register file geometry
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS = 32;

    // what a retiring slot does
    typedef enum logic [3:0] {
        // no architectural effect
        OP_NONE = 4'd0,
        // rdst <= value
        OP_ALU  = 4'd1,
        // hi <= value
        OP_MTHI = 4'd2,
        // lo <= value
        OP_MTLO = 4'd3,
        // {hi, lo} <= product
        OP_MULT = 4'd4,
        // {hi, lo} <= {hi, lo} + product
        OP_MADD = 4'd5,
        // {hi, lo} <= {hi, lo} - product
        OP_MSUB = 4'd6,
        // rdst <= hi seen by the slot
        OP_MFHI = 4'd7,
        // rdst <= lo seen by the slot
        OP_MFLO = 4'd8
    } retire_op_t;

endpackage

`default_nettype wire

/* design/writeback_select.sv */
`timescale 1ns/1ns
`default_nettype none

module writeback_select (
    input  logic                              i_old_valid,
    input  logic                              i_new_valid,
    input  retire_pkg::retire_op_t            i_old_op,
    input  retire_pkg::retire_op_t            i_new_op,
    input  logic [retire_pkg::REG_ADDR_W-1:0] i_old_rdst,
    input  logic [retire_pkg::REG_ADDR_W-1:0] i_new_rdst,
    input  logic [retire_pkg::WORD_W-1:0]     i_old_value,
    input  logic [retire_pkg::WORD_W-1:0]     i_new_value,
    input  logic [retire_pkg::WORD_W-1:0]     i_hi,
    input  logic [retire_pkg::WORD_W-1:0]     i_lo,
    input  logic [retire_pkg::WORD_W-1:0]     i_mid_hi,
    input  logic [retire_pkg::WORD_W-1:0]     i_mid_lo,
    output logic                              o_old_we,
    output logic                              o_new_we,
    output logic [retire_pkg::REG_ADDR_W-1:0] o_old_wa,
    output logic [retire_pkg::REG_ADDR_W-1:0] o_new_wa,
    output logic [retire_pkg::WORD_W-1:0]     o_old_wd,
    output logic [retire_pkg::WORD_W-1:0]     o_new_wd
);

    // ops that end in a register write
    function automatic logic writes_reg(input logic valid, input retire_pkg::retire_op_t op);
        return valid && (op == retire_pkg::OP_ALU || op == retire_pkg::OP_MFHI ||
                         op == retire_pkg::OP_MFLO);
    endfunction

    function automatic logic [retire_pkg::WORD_W-1:0] write_data(
        input retire_pkg::retire_op_t        op,
        input logic [retire_pkg::WORD_W-1:0] value,
        input logic [retire_pkg::WORD_W-1:0] hi,
        input logic [retire_pkg::WORD_W-1:0] lo
    );
        case (op)
            retire_pkg::OP_MFHI: return hi;
            retire_pkg::OP_MFLO: return lo;
            default:             return value;
        endcase
    endfunction

    assign o_old_we = writes_reg(i_old_valid, i_old_op);
    assign o_new_we = writes_reg(i_new_valid, i_new_op);
    assign o_old_wa = i_old_rdst;
    assign o_new_wa = i_new_rdst;

    // older slot reads the stored pair, newer slot the pair after the older one
    assign o_old_wd = write_data(i_old_op, i_old_value, i_hi, i_lo);
    assign o_new_wd = write_data(i_new_op, i_new_value, i_mid_hi, i_mid_lo);

endmodule

`default_nettype wire

/* src.f */
design/retire_pkg.sv
design/hilo_unit.sv
design/writeback_select.sv
design/gpr_file.sv
design/retire_core.sv
verification/retire_checker.sv
verification/tb_retire.sv

/* verification/retire_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module retire_checker (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              i_old_valid, i_new_valid,
    input  retire_pkg::retire_op_t            i_old_op, i_new_op,
    input  logic [retire_pkg::REG_ADDR_W-1:0] i_old_rdst, i_new_rdst, i_ra_a, i_ra_b,
    input  logic [retire_pkg::WORD_W-1:0]     i_old_value, i_new_value,
    input  logic [retire_pkg::DWORD_W-1:0]    i_old_product, i_new_product,
    input  logic [retire_pkg::WORD_W-1:0]     o_rd_a, o_rd_b, o_hi, o_lo,
    output logic                              o_active,
    output int                                o_checks,
    output int                                o_errors
);

    logic [retire_pkg::WORD_W-1:0]  model_regs [0:retire_pkg::NUM_REGS-1];
    logic [retire_pkg::WORD_W-1:0]  model_hi;
    logic [retire_pkg::WORD_W-1:0]  model_lo;
    logic [retire_pkg::DWORD_W-1:0] mid_pair;
    logic [retire_pkg::DWORD_W-1:0] next_pair;
    int phase_checks;
    int phase_errors;
    int tests;

    // {hi, lo} after one slot with 64-bit wraparound
    function automatic logic [63:0] hilo_after(input logic valid,
        input retire_pkg::retire_op_t op, input logic [31:0] value,
        input logic [63:0] product, input logic [63:0] pair);
        if (!valid) return pair;
        case (op)
            retire_pkg::OP_MTHI: return {value, pair[31:0]};
            retire_pkg::OP_MTLO: return {pair[63:32], value};
            retire_pkg::OP_MULT: return product;
            retire_pkg::OP_MADD: return pair + product;
            retire_pkg::OP_MSUB: return pair - product;
            default:             return pair;
        endcase
    endfunction

    task automatic check_word(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %0t %s expected %h actual %h", $time, name, expected, actual);
            o_errors++;
            phase_errors++;
        end
    endtask

    always @(negedge clk) begin
        if (reset) begin
            for (int r = 0; r < retire_pkg::NUM_REGS; r++) begin
                model_regs[r] = '0;
            end
            model_hi = '0;
            model_lo = '0;
            o_active = 1'b0;
        end else begin
            mid_pair = hilo_after(i_old_valid, i_old_op, i_old_value, i_old_product,
                                  {model_hi, model_lo});
            next_pair = hilo_after(i_new_valid, i_new_op, i_new_value, i_new_product,
                                   mid_pair);
            check_word("o_hi", model_hi, o_hi);
            check_word("o_lo", model_lo, o_lo);
            // older write first, the newer one lands on top
            if (i_old_valid && i_old_rdst != 0) begin
                case (i_old_op)
                    retire_pkg::OP_ALU:  model_regs[i_old_rdst] = i_old_value;
                    retire_pkg::OP_MFHI: model_regs[i_old_rdst] = model_hi;
                    retire_pkg::OP_MFLO: model_regs[i_old_rdst] = model_lo;
                    default:             ;
                endcase
            end
            if (i_new_valid && i_new_rdst != 0) begin
                case (i_new_op)
                    retire_pkg::OP_ALU:  model_regs[i_new_rdst] = i_new_value;
                    retire_pkg::OP_MFHI: model_regs[i_new_rdst] = mid_pair[63:32];
                    retire_pkg::OP_MFLO: model_regs[i_new_rdst] = mid_pair[31:0];
                    default:             ;
                endcase
            end
            // read ports show the state after this cycle's writes
            check_word("o_rd_a", model_regs[i_ra_a], o_rd_a);
            check_word("o_rd_b", model_regs[i_ra_b], o_rd_b);
            {model_hi, model_lo} = next_pair;
            o_active = 1'b1;
            o_checks++;
            phase_checks++;
        end
    end

    task automatic end_phase(input string name);
        tests++;
        $display("test %0d %s: %0d checks, %0d mismatches", tests, name, phase_checks,
                 phase_errors);
        phase_checks = 0;
        phase_errors = 0;
    endtask

    task automatic print_summary();
        $display("summary: %0d tests, %0d checks, %0d mismatches", tests, o_checks, o_errors);
    endtask

endmodule

`default_nettype wire

/* verification/tb_retire.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_retire;

    logic                              clk;
    logic                              reset;
    logic                              i_old_valid, i_new_valid;
    retire_pkg::retire_op_t            i_old_op, i_new_op;
    logic [retire_pkg::REG_ADDR_W-1:0] i_old_rdst, i_new_rdst, i_ra_a, i_ra_b;
    logic [retire_pkg::WORD_W-1:0]     i_old_value, i_new_value;
    logic [retire_pkg::DWORD_W-1:0]    i_old_product, i_new_product;
    logic [retire_pkg::WORD_W-1:0]     o_rd_a, o_rd_b, o_hi, o_lo;
    logic                              checker_active;
    int                                checks;
    int                                errors;
    integer                            seed;

    retire_core i_retire_core (.*);

    retire_checker i_retire_checker (
        .*,
        .o_active (checker_active),
        .o_checks (checks),
        .o_errors (errors)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic drive_old(input retire_pkg::retire_op_t op, input logic [4:0] rdst,
        input logic [31:0] value, input logic [63:0] product);
        i_old_valid <= 1'b1;
        i_old_op <= op;
        i_old_rdst <= rdst;
        i_old_value <= value;
        i_old_product <= product;
    endtask

    task automatic drive_new(input retire_pkg::retire_op_t op, input logic [4:0] rdst,
        input logic [31:0] value, input logic [63:0] product);
        i_new_valid <= 1'b1;
        i_new_op <= op;
        i_new_rdst <= rdst;
        i_new_value <= value;
        i_new_product <= product;
    endtask

    task automatic idle_slots();
        i_old_valid <= 1'b0;
        i_new_valid <= 1'b0;
        i_old_op <= retire_pkg::OP_NONE;
        i_new_op <= retire_pkg::OP_NONE;
    endtask

    task automatic drive_random();
        logic [3:0] op_o;
        logic [3:0] op_n;
        op_o = $unsigned($random(seed)) % 9;
        op_n = $unsigned($random(seed)) % 9;
        // small destination range keeps collisions and forwarding frequent
        drive_old(retire_pkg::retire_op_t'(op_o), $random(seed) & 15, $random(seed),
                  {$random(seed), $random(seed)});
        drive_new(retire_pkg::retire_op_t'(op_n), $random(seed) & 15, $random(seed),
                  {$random(seed), $random(seed)});
        i_old_valid <= ($random(seed) & 3) != 0;
        i_new_valid <= ($random(seed) & 3) != 0;
        i_ra_a <= $random(seed) & 15;
        i_ra_b <= $random(seed);
    endtask

    // idle until the last driven cycle and its hi/lo update are checked
    task automatic finish_phase(input string name);
        int target;
        int waited;
        target = checks + 2;
        waited = 0;
        while (checks < target) begin
            @(posedge clk);
            idle_slots();
            waited++;
            if (waited > 20) begin
                $display("timeout: checker stopped comparing during %s", name);
                $display("Errors found");
                $finish;
            end
        end
        i_retire_checker.end_phase(name);
    endtask

    initial begin
        int waited;
        seed = 32'h830b;
        reset = 1'b1;
        i_old_valid = 1'b0;
        i_new_valid = 1'b0;
        i_old_op = retire_pkg::OP_NONE;
        i_new_op = retire_pkg::OP_NONE;
        i_old_rdst = '0;
        i_new_rdst = '0;
        i_old_value = '0;
        i_new_value = '0;
        i_old_product = '0;
        i_new_product = '0;
        i_ra_a = '0;
        i_ra_b = '0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        waited = 0;
        while (!checker_active) begin
            @(posedge clk);
            waited++;
            if (waited > 20) begin
                $display("timeout: reset release never reached the checker");
                $display("Errors found");
                $finish;
            end
        end

        // every register from both ports
        for (int i = 0; i < retire_pkg::NUM_REGS; i++) begin
            @(posedge clk);
            i_ra_a <= i;
            i_ra_b <= retire_pkg::NUM_REGS - 1 - i;
        end
        finish_phase("reset");

        // first pair writes register 0
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            drive_old(retire_pkg::OP_ALU, i * 4, 32'h1000_0000 + i, '0);
            drive_new(retire_pkg::OP_ALU, i * 4 + 1, 32'h2000_0000 + i, '0);
            i_ra_a <= i * 4;
            i_ra_b <= i * 4 + 1;
        end
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            idle_slots();
            i_ra_a <= i;
            i_ra_b <= 31 - i;
        end
        finish_phase("alu writes");

        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            drive_old(retire_pkg::OP_ALU, 9 + i, 32'haaaa_0000 + i, '0);
            drive_new(retire_pkg::OP_ALU, 9 + i, 32'h5555_0000 + i, '0);
            i_ra_a <= 9 + i;
            i_ra_b <= 9;
        end
        finish_phase("collision");

        @(posedge clk);
        drive_old(retire_pkg::OP_MTHI, 0, 32'hdead_beef, '0);
        drive_new(retire_pkg::OP_MFHI, 3, 32'h0, '0);
        i_ra_a <= 3;
        @(posedge clk);
        drive_old(retire_pkg::OP_MTLO, 0, 32'h1234_5678, '0);
        drive_new(retire_pkg::OP_MFLO, 4, 32'h0, '0);
        i_ra_a <= 4;
        i_ra_b <= 3;
        @(posedge clk);
        drive_old(retire_pkg::OP_MULT, 0, 32'h0, 64'h0123_4567_89ab_cdef);
        drive_new(retire_pkg::OP_MFHI, 5, 32'h0, '0);
        i_ra_a <= 5;
        // older mflo sees the stored lo, not the newer mthi
        @(posedge clk);
        drive_old(retire_pkg::OP_MFLO, 6, 32'h0, '0);
        drive_new(retire_pkg::OP_MTHI, 0, 32'h0f0f_0f0f, '0);
        i_ra_a <= 6;
        finish_phase("hi/lo moves");

        @(posedge clk);
        drive_old(retire_pkg::OP_MULT, 0, 32'h0, 64'hffff_ffff_ffff_fff0);
        drive_new(retire_pkg::OP_MADD, 0, 32'h0, 64'h20);
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            drive_old(retire_pkg::retire_op_t'((i % 2) ? retire_pkg::OP_MSUB
                                                       : retire_pkg::OP_MADD),
                      0, 32'h0, {$random(seed), $random(seed)});
            drive_new(retire_pkg::retire_op_t'((i % 3) ? retire_pkg::OP_MADD
                                                       : retire_pkg::OP_MSUB),
                      7, 32'h0, {$random(seed), $random(seed)});
        end
        finish_phase("accumulation");

        for (int i = 0; i < 2000; i++) begin
            @(posedge clk);
            drive_random();
        end
        finish_phase("random mix");

        i_retire_checker.print_summary();
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
